// ==== Bender.yml ====
package:
  name: lander_io

sources:
  - rtl/lander_pkg.sv
  - rtl/pad_input_mapper.sv
  - rtl/thrust_ramp.sv
  - rtl/difficulty_indicator.sv
  - rtl/video_out_stage.sv
  - rtl/i2s_audio_tx.sv
  - rtl/lander_io_top.sv
  - target: test
    files:
      - testbench/tb_lander_io.sv

// ==== list.f ====
rtl/lander_pkg.sv
rtl/pad_input_mapper.sv
rtl/thrust_ramp.sv
rtl/difficulty_indicator.sv
rtl/video_out_stage.sv
rtl/i2s_audio_tx.sv
rtl/lander_io_top.sv
testbench/tb_lander_io.sv

// ==== rtl/difficulty_indicator.sv ====
/*
  difficulty comes from the highest lit lamp, one clock later
  overlay stays on for OVERLAY_HOLD_CYCLES after Select is released
*/
`timescale 1ns/100ps

module difficulty_indicator #(
  parameter int OVERLAY_HOLD_CYCLES = 500000000
) (
  input  logic                    clk_50,
  input  logic                    i_rst_n,
  input  lander_pkg::lamp_bits_t  i_lamps,
  input  logic                    i_select_held,
  output lander_pkg::difficulty_t o_difficulty,
  output logic                    o_overlay_en
);
  import lander_pkg::*;

  localparam int HOLD_W = $clog2(OVERLAY_HOLD_CYCLES + 1);
  localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(OVERLAY_HOLD_CYCLES);

  difficulty_t       level;
  logic [HOLD_W-1:0] hold_cnt;
  logic [HOLD_W-1:0] hold_next;

  ////////////////////////////////////////////////////////////
  // lamp decode
  ////////////////////////////////////////////////////////////

  // lamp5 highest, lamp2 alone means easiest
  always_comb begin
    if (i_lamps[3]) begin
      level = 2'd3;
    end else if (i_lamps[2]) begin
      level = 2'd2;
    end else if (i_lamps[1]) begin
      level = 2'd1;
    end else begin
      level = 2'd0;
    end
  end

  ////////////////////////////////////////////////////////////
  // overlay hold timer
  ////////////////////////////////////////////////////////////

  // reload while held, then count down to zero
  always_comb begin
    if (i_select_held) begin
      hold_next = HOLD_LOAD;
    end else if (hold_cnt != '0) begin
      hold_next = hold_cnt - 1'b1;
    end else begin
      hold_next = '0;
    end
  end

  // enable taken from the next count, so it rises with the reload
  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_difficulty <= '0;
      hold_cnt     <= '0;
      o_overlay_en <= 1'b0;
    end else begin
      o_difficulty <= level;
      hold_cnt     <= hold_next;
      o_overlay_en <= (hold_next != '0);
    end
  end

endmodule

// ==== rtl/i2s_audio_tx.sv ====
/*
  mclk, sclk and lrck are made from clk_50 with clock enables
  each channel is 32 sclk long, 16 data bits MSB first then zeros
  the sample is captured when lrck falls and reused for the right channel
*/
`timescale 1ns/100ps

module i2s_audio_tx (
  input  logic                      clk_50,
  input  logic                      i_rst_n,
  input  lander_pkg::audio_sample_t i_audio,
  output logic                      o_mclk,
  output logic                      o_sclk,
  output logic                      o_lrck,
  output logic                      o_dac
);
  import lander_pkg::*;

  localparam int ACC_W  = $clog2(MCLK_MOD + MCLK_INC);
  localparam int SLOT_W = $clog2(I2S_SLOT_BITS);

  // 16-bit word, leading 0 then audio[7:1], twice
  function automatic logic [I2S_ACTIVE_BITS-1:0] audio_word(input audio_sample_t s);
    return {1'b0, s[7:1], 1'b0, s[7:1]};
  endfunction

  logic [ACC_W-1:0]           mclk_acc;
  logic [ACC_W-1:0]           acc_sum;
  logic                       mclk_wrap;
  logic                       mclk_rise;
  logic [SCLK_DIV_BITS-1:0]   sclk_div;
  logic                       sclk_fall;
  logic [SLOT_W-1:0]          slot_cnt;
  logic                       slot_last;
  logic [I2S_ACTIVE_BITS-1:0] shift_q;
  logic [I2S_ACTIVE_BITS-1:0] load_word;
  audio_sample_t              sample_q;

  ////////////////////////////////////////////////////////////
  // fractional mclk
  ////////////////////////////////////////////////////////////

  assign acc_sum   = mclk_acc + ACC_W'(MCLK_INC);
  assign mclk_wrap = (acc_sum >= ACC_W'(MCLK_MOD));
  // mclk is about to go high
  assign mclk_rise = mclk_wrap & ~o_mclk;

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mclk_acc <= '0;
      o_mclk   <= 1'b0;
    end else if (mclk_wrap) begin
      mclk_acc <= acc_sum - ACC_W'(MCLK_MOD);
      o_mclk   <= ~o_mclk;
    end else begin
      mclk_acc <= acc_sum;
    end
  end

  ////////////////////////////////////////////////////////////
  // sclk divider
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sclk_div <= '0;
    end else if (mclk_rise) begin
      sclk_div <= sclk_div + 1'b1;
    end
  end

  assign o_sclk = sclk_div[SCLK_DIV_BITS-1];
  // divider wraps, sclk goes low
  assign sclk_fall = mclk_rise & (sclk_div == '1);

  ////////////////////////////////////////////////////////////
  // channel framing and shifter
  ////////////////////////////////////////////////////////////

  assign slot_last = (slot_cnt == SLOT_W'(I2S_SLOT_BITS - 1));
  // left channel takes a fresh sample, right reuses it
  assign load_word = o_lrck ? audio_word(i_audio) : audio_word(sample_q);

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      slot_cnt <= '0;
      o_lrck   <= 1'b0;
      o_dac    <= 1'b0;
      shift_q  <= '0;
      sample_q <= '0;
    end else if (sclk_fall) begin
      slot_cnt <= slot_cnt + 1'b1;
      if (slot_last) begin
        // new channel, MSB goes out together with the lrck edge
        o_lrck  <= ~o_lrck;
        o_dac   <= load_word[I2S_ACTIVE_BITS-1];
        shift_q <= {load_word[I2S_ACTIVE_BITS-2:0], 1'b0};
        if (o_lrck) begin
          sample_q <= i_audio;
        end
      end else begin
        // zeros fill in once the word is out
        o_dac   <= shift_q[I2S_ACTIVE_BITS-1];
        shift_q <= {shift_q[I2S_ACTIVE_BITS-2:0], 1'b0};
      end
    end
  end

endmodule

// ==== rtl/lander_io_top.sv ====
/*
  glue between the lander game core and the handheld outputs
  single clock domain, everything on clk_50
  tick and hold lengths are set through the two parameters
*/
`timescale 1ns/100ps

module lander_io_top #(
  parameter int THRUST_TICK_CYCLES  = 196850,
  parameter int OVERLAY_HOLD_CYCLES = 500000000
) (
  input  logic                      clk_50,
  input  logic                      i_rst_n,
  // from the pads and the game core
  input  lander_pkg::pad_key_t      i_pad1_key,
  input  lander_pkg::pad_key_t      i_pad2_key,
  input  lander_pkg::lamp_bits_t    i_lamps,
  input  logic                      i_pix_en,
  input  lander_pkg::game_video_t   i_video,
  input  lander_pkg::audio_sample_t i_audio,
  // towards the game core and overlay
  output lander_pkg::game_ctrl_t    o_game_ctrl,
  output lander_pkg::thrust_t       o_thrust,
  output lander_pkg::difficulty_t   o_difficulty,
  output logic                      o_overlay_en,
  // video out
  output lander_pkg::rgb24_t        o_rgb,
  output logic                      o_de,
  output logic                      o_hs,
  output logic                      o_vs,
  // i2s out
  output logic                      o_mclk,
  output logic                      o_sclk,
  output logic                      o_lrck,
  output logic                      o_dac
);

  ////////////////////////////////////////////////////////////
  // controls
  ////////////////////////////////////////////////////////////

  pad_input_mapper u_pad_input_mapper (
    .clk_50     (clk_50),
    .i_rst_n    (i_rst_n),
    .i_pad1_key (i_pad1_key),
    .i_pad2_key (i_pad2_key),
    .o_ctrl     (o_game_ctrl)
  );

  // held A and B drive the ramp
  thrust_ramp #(
    .THRUST_TICK_CYCLES (THRUST_TICK_CYCLES)
  ) u_thrust_ramp (
    .clk_50        (clk_50),
    .i_rst_n       (i_rst_n),
    .i_thrust_up   (o_game_ctrl.thrust_up),
    .i_thrust_down (o_game_ctrl.thrust_down),
    .o_thrust      (o_thrust)
  );

  difficulty_indicator #(
    .OVERLAY_HOLD_CYCLES (OVERLAY_HOLD_CYCLES)
  ) u_difficulty_indicator (
    .clk_50        (clk_50),
    .i_rst_n       (i_rst_n),
    .i_lamps       (i_lamps),
    .i_select_held (o_game_ctrl.select_held),
    .o_difficulty  (o_difficulty),
    .o_overlay_en  (o_overlay_en)
  );

  ////////////////////////////////////////////////////////////
  // video and audio
  ////////////////////////////////////////////////////////////

  video_out_stage u_video_out_stage (
    .clk_50   (clk_50),
    .i_rst_n  (i_rst_n),
    .i_pix_en (i_pix_en),
    .i_video  (i_video),
    .o_rgb    (o_rgb),
    .o_de     (o_de),
    .o_hs     (o_hs),
    .o_vs     (o_vs)
  );

  i2s_audio_tx u_i2s_audio_tx (
    .clk_50  (clk_50),
    .i_rst_n (i_rst_n),
    .i_audio (i_audio),
    .o_mclk  (o_mclk),
    .o_sclk  (o_sclk),
    .o_lrck  (o_lrck),
    .o_dac   (o_dac)
  );

endmodule

// ==== rtl/lander_pkg.sv ====
/*
  types and constants shared by the lander i/o glue blocks
  key positions follow the handheld controller bitmap, 1 = pressed
  audio constants assume a 50 MHz clk_50
*/
package lander_pkg;

  ////////////////////////////////////////////////////////////
  // plain vector types
  ////////////////////////////////////////////////////////////

  // one controller key bitmap
  typedef logic [15:0] pad_key_t;
  // thrust level handed to the game
  typedef logic [7:0]  thrust_t;
  // 0 easiest, 3 hardest
  typedef logic [1:0]  difficulty_t;
  // bit 0 is lamp2, bit 3 is lamp5
  typedef logic [3:0]  lamp_bits_t;
  // unsigned game audio
  typedef logic [7:0]  audio_sample_t;
  // r in [23:16], b in [7:0]
  typedef logic [23:0] rgb24_t;
  // one game colour channel
  typedef logic [2:0]  color3_t;

  ////////////////////////////////////////////////////////////
  // grouped signals
  ////////////////////////////////////////////////////////////

  // levels towards the game core
  typedef struct packed {
    logic select_l;
    logic start_l;
    logic turn_l_l;
    logic turn_r_l;
    logic coin_l;
    logic abort_l;
    // held levels, active high
    logic thrust_up;
    logic thrust_down;
    logic select_held;
  } game_ctrl_t;

  // raw game video
  typedef struct packed {
    color3_t r;
    color3_t g;
    color3_t b;
    logic    hs;
    logic    vs;
    logic    hblank;
    logic    vblank;
  } game_video_t;

  ////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////

  // key bit positions
  localparam int KEY_LEFT   = 2;
  localparam int KEY_RIGHT  = 3;
  localparam int KEY_A      = 4;
  localparam int KEY_B      = 5;
  localparam int KEY_L1     = 8;
  localparam int KEY_R1     = 9;
  localparam int KEY_SELECT = 14;
  localparam int KEY_START  = 15;

  // top of the thrust range
  localparam thrust_t THRUST_MAX = 8'd254;

  // mclk toggles at 50 MHz * INC / MOD, about 24.576 MHz, so 12.288 MHz clock
  localparam int MCLK_INC = 245760;
  localparam int MCLK_MOD = 500000;

  // sclk is mclk / 4
  localparam int SCLK_DIV_BITS = 2;
  // bits per channel, of which the first ones carry data
  localparam int I2S_SLOT_BITS   = 32;
  localparam int I2S_ACTIVE_BITS = 16;

endpackage

// ==== rtl/pad_input_mapper.sv ====
/*
  both pads are asynchronous and pass a two-flop synchroniser
  a key counts as pressed when it is pressed on either pad
  o_ctrl follows a pad change after exactly two clocks
*/
`timescale 1ns/100ps

module pad_input_mapper (
  input  logic                   clk_50,
  input  logic                   i_rst_n,
  input  lander_pkg::pad_key_t   i_pad1_key,
  input  lander_pkg::pad_key_t   i_pad2_key,
  output lander_pkg::game_ctrl_t o_ctrl
);
  import lander_pkg::*;

  // first and second sync stage per pad
  pad_key_t pad1_meta;
  pad_key_t pad1_sync;
  pad_key_t pad2_meta;
  pad_key_t pad2_sync;
  pad_key_t merged;

  ////////////////////////////////////////////////////////////
  // synchroniser
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pad1_meta <= '0;
      pad1_sync <= '0;
      pad2_meta <= '0;
      pad2_sync <= '0;
    end else begin
      pad1_meta <= i_pad1_key;
      pad1_sync <= pad1_meta;
      pad2_meta <= i_pad2_key;
      pad2_sync <= pad2_meta;
    end
  end

  // either pad presses the key
  assign merged = pad1_sync | pad2_sync;

  ////////////////////////////////////////////////////////////
  // key map
  ////////////////////////////////////////////////////////////

  always_comb begin
    // game side is active low
    o_ctrl.select_l    = ~merged[KEY_SELECT];
    o_ctrl.start_l     = ~merged[KEY_START];
    o_ctrl.turn_l_l    = ~merged[KEY_LEFT];
    o_ctrl.turn_r_l    = ~merged[KEY_RIGHT];
    // r1 drops a coin, l1 aborts
    o_ctrl.coin_l      = ~merged[KEY_R1];
    o_ctrl.abort_l     = ~merged[KEY_L1];
    // held levels for thrust and overlay
    o_ctrl.thrust_up   = merged[KEY_A];
    o_ctrl.thrust_down = merged[KEY_B];
    o_ctrl.select_held = merged[KEY_SELECT];
  end

  // select path from both pads, two clocks, both polarities agree
  a_select_path: assert property (
    @(posedge clk_50) disable iff (!i_rst_n)
    ($past(i_rst_n, 2) && $past(i_rst_n)) |->
      (o_ctrl.select_held == $past(i_pad1_key[KEY_SELECT] | i_pad2_key[KEY_SELECT], 2)) &&
      (o_ctrl.select_l == ~o_ctrl.select_held)
  );

endmodule

// ==== rtl/thrust_ramp.sv ====
/*
  thrust moves one step per tick while A or B is held
  A wins when both are held, range is 0 to THRUST_MAX
  THRUST_TICK_CYCLES must be at least 2
*/
`timescale 1ns/100ps

module thrust_ramp #(
  parameter int THRUST_TICK_CYCLES = 196850
) (
  input  logic                clk_50,
  input  logic                i_rst_n,
  input  logic                i_thrust_up,
  input  logic                i_thrust_down,
  output lander_pkg::thrust_t o_thrust
);
  import lander_pkg::*;

  localparam int TICK_W = (THRUST_TICK_CYCLES > 1) ? $clog2(THRUST_TICK_CYCLES) : 1;
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(THRUST_TICK_CYCLES - 1);

  logic [TICK_W-1:0] tick_cnt;
  logic              tick;

  ////////////////////////////////////////////////////////////
  // tick divider
  ////////////////////////////////////////////////////////////

  assign tick = (tick_cnt == TICK_LAST);

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // saturating thrust value
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_thrust <= '0;
    end else if (tick) begin
      // up first, down only if up is blocked
      if (i_thrust_up && (o_thrust < THRUST_MAX)) begin
        o_thrust <= o_thrust + 1'b1;
      end else if (i_thrust_down && (o_thrust != '0)) begin
        o_thrust <= o_thrust - 1'b1;
      end
    end
  end

  a_thrust_limit: assert property (
    @(posedge clk_50) disable iff (!i_rst_n)
    o_thrust <= THRUST_MAX
  );

endmodule

// ==== rtl/video_out_stage.sv ====
/*
  all registers advance only on cycles with i_pix_en high
  3-bit colour widens to 8 bits by bit replication
  sync outputs are one-update pulses on the rising edge of the game sync
*/
`timescale 1ns/100ps

module video_out_stage (
  input  logic                    clk_50,
  input  logic                    i_rst_n,
  input  logic                    i_pix_en,
  input  lander_pkg::game_video_t i_video,
  output lander_pkg::rgb24_t      o_rgb,
  output logic                    o_de,
  output logic                    o_hs,
  output logic                    o_vs
);
  import lander_pkg::*;

  // c, c, c[2:1] fills 8 bits
  function automatic logic [7:0] expand3(input color3_t c);
    return {c, c, c[2:1]};
  endfunction

  logic   blank;
  rgb24_t rgb_next;
  // sync levels from the last update
  logic   hs_prev;
  logic   vs_prev;

  ////////////////////////////////////////////////////////////
  // colour and blanking
  ////////////////////////////////////////////////////////////

  assign blank = i_video.hblank | i_video.vblank;

  always_comb begin
    if (blank) begin
      rgb_next = '0;
    end else begin
      rgb_next = {expand3(i_video.r), expand3(i_video.g), expand3(i_video.b)};
    end
  end

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rgb   <= '0;
      o_de    <= 1'b0;
      o_hs    <= 1'b0;
      o_vs    <= 1'b0;
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end else if (i_pix_en) begin
      o_rgb   <= rgb_next;
      o_de    <= ~blank;
      // rising edge of the game sync
      o_hs    <= i_video.hs & ~hs_prev;
      o_vs    <= i_video.vs & ~vs_prev;
      hs_prev <= i_video.hs;
      vs_prev <= i_video.vs;
    end
  end

  a_blank_black: assert property (
    @(posedge clk_50) disable iff (!i_rst_n)
    !o_de |-> (o_rgb == '0)
  );

  // an hs pulse lasts one update only
  a_hs_single: assert property (
    @(posedge clk_50) disable iff (!i_rst_n)
    (i_pix_en && o_hs) |=> !o_hs
  );

endmodule

// ==== testbench/tb_lander_io.sv ====
/*
  testbench for lander_io_top with short thrust tick and overlay hold
  checks sample on the falling clock edge, where all outputs are stable
  stimulus threads run side by side, a cycle counter bounds the run
*/
`timescale 1ns/100ps

module tb_lander_io;
  import lander_pkg::*;

  localparam int TICK_CYCLES = 16;
  localparam int HOLD_CYCLES = 40;
  localparam int SWEEP_TICKS = 300;
  localparam int SLOT_BITS   = 32;
  localparam int WORD_BITS   = 16;
  // thrust sweep is the longest thread, twice it plus margin
  localparam int TIMEOUT_CYCLES = 2 * (2 * SWEEP_TICKS * TICK_CYCLES) + 800;

  logic          clk_50;
  logic          i_rst_n;
  pad_key_t      i_pad1_key;
  pad_key_t      i_pad2_key;
  lamp_bits_t    i_lamps;
  logic          i_pix_en;
  game_video_t   i_video;
  audio_sample_t i_audio;
  game_ctrl_t    o_game_ctrl;
  thrust_t       o_thrust;
  difficulty_t   o_difficulty;
  logic          o_overlay_en;
  rgb24_t        o_rgb;
  logic          o_de;
  logic          o_hs;
  logic          o_vs;
  logic          o_mclk;
  logic          o_sclk;
  logic          o_lrck;
  logic          o_dac;

  int err_ctrl   = 0;
  int err_thrust = 0;
  int err_diff   = 0;
  int err_video  = 0;
  int err_audio  = 0;
  int cycle_cnt  = 0;

  // reference state, pads two clocks back, lamps one clock back
  pad_key_t               pad1_d1;
  pad_key_t               pad1_d2;
  pad_key_t               pad2_d1;
  pad_key_t               pad2_d2;
  lamp_bits_t             lamps_d1;
  // select history, bit 0 newest
  logic [HOLD_CYCLES-1:0] sel_hist;
  rgb24_t                 exp_rgb;
  logic                   exp_de;
  logic                   exp_hs;
  logic                   exp_vs;
  logic                   hs_last;
  logic                   vs_last;
  // i2s receiver state
  logic                   sclk_q;
  logic                   lrck_q;
  logic                   chan_valid;
  int                     bit_idx;
  int                     frames_seen;
  logic [WORD_BITS-1:0]   exp_word;
  logic                   exp_bit;
  // mclk rate and sclk ratio
  logic                   mclk_q;
  logic                   mclk_seen;
  int                     mclk_gap;
  int                     mclk_per_sclk;
  logic                   sclk_started;

  lander_io_top #(
    .THRUST_TICK_CYCLES  (TICK_CYCLES),
    .OVERLAY_HOLD_CYCLES (HOLD_CYCLES)
  ) DUT (
    .clk_50       (clk_50),
    .i_rst_n      (i_rst_n),
    .i_pad1_key   (i_pad1_key),
    .i_pad2_key   (i_pad2_key),
    .i_lamps      (i_lamps),
    .i_pix_en     (i_pix_en),
    .i_video      (i_video),
    .i_audio      (i_audio),
    .o_game_ctrl  (o_game_ctrl),
    .o_thrust     (o_thrust),
    .o_difficulty (o_difficulty),
    .o_overlay_en (o_overlay_en),
    .o_rgb        (o_rgb),
    .o_de         (o_de),
    .o_hs         (o_hs),
    .o_vs         (o_vs),
    .o_mclk       (o_mclk),
    .o_sclk       (o_sclk),
    .o_lrck       (o_lrck),
    .o_dac        (o_dac)
  );

  ////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////

  // merged keys to game levels, game side active low
  function automatic game_ctrl_t map_keys(input pad_key_t k);
    game_ctrl_t c;
    c.select_l    = !k[KEY_SELECT];
    c.start_l     = !k[KEY_START];
    c.turn_l_l    = !k[KEY_LEFT];
    c.turn_r_l    = !k[KEY_RIGHT];
    c.coin_l      = !k[KEY_R1];
    c.abort_l     = !k[KEY_L1];
    c.thrust_up   = k[KEY_A];
    c.thrust_down = k[KEY_B];
    c.select_held = k[KEY_SELECT];
    return c;
  endfunction

  // highest lit lamp wins, lamp2 alone is level 0
  function automatic difficulty_t lamp_level(input lamp_bits_t l);
    casez (l)
      4'b1???: return 2'd3;
      4'b01??: return 2'd2;
      4'b001?: return 2'd1;
      default: return 2'd0;
    endcase
  endfunction

  function automatic rgb24_t widen_color(input game_video_t v);
    if (v.hblank || v.vblank) begin
      return '0;
    end
    return {v.r, v.r, v.r[2:1], v.g, v.g, v.g[2:1], v.b, v.b, v.b[2:1]};
  endfunction

  always @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pad1_d1  <= '0;
      pad1_d2  <= '0;
      pad2_d1  <= '0;
      pad2_d2  <= '0;
      lamps_d1 <= '0;
      sel_hist <= '0;
      exp_rgb  <= '0;
      exp_de   <= 1'b0;
      exp_hs   <= 1'b0;
      exp_vs   <= 1'b0;
      hs_last  <= 1'b0;
      vs_last  <= 1'b0;
    end else begin
      pad1_d1  <= i_pad1_key;
      pad1_d2  <= pad1_d1;
      pad2_d1  <= i_pad2_key;
      pad2_d2  <= pad2_d1;
      lamps_d1 <= i_lamps;
      // overlay is on while select was held within the last HOLD_CYCLES
      sel_hist <= {sel_hist[HOLD_CYCLES-2:0], pad1_d2[KEY_SELECT] | pad2_d2[KEY_SELECT]};
      if (i_pix_en) begin
        exp_rgb <= widen_color(i_video);
        exp_de  <= !(i_video.hblank || i_video.vblank);
        exp_hs  <= i_video.hs && !hs_last;
        exp_vs  <= i_video.vs && !vs_last;
        hs_last <= i_video.hs;
        vs_last <= i_video.vs;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_ctrl: assert property (@(negedge clk_50) disable iff (!i_rst_n)
    o_game_ctrl == map_keys(pad1_d2 | pad2_d2))
    else begin
      err_ctrl++;
      $display("Mismatch o_game_ctrl exp %h got %h", map_keys(pad1_d2 | pad2_d2), o_game_ctrl);
    end

  a_thrust_max: assert property (@(negedge clk_50) disable iff (!i_rst_n)
    o_thrust <= 8'd254)
    else begin
      err_thrust++;
      $display("o_thrust went above 254, value %h", o_thrust);
    end

  a_thrust_step: assert property (@(negedge clk_50) disable iff (!i_rst_n)
    (o_thrust == $past(o_thrust)) || (o_thrust == $past(o_thrust) + 8'd1) ||
    ($past(o_thrust) == o_thrust + 8'd1))
    else begin
      err_thrust++;
      $display("o_thrust moved by more than one step, now %h", o_thrust);
    end

  // saturated with A held stays put
  a_thrust_hold: assert property (@(negedge clk_50) disable iff (!i_rst_n)
    (o_thrust == 8'd254 && o_game_ctrl.thrust_up) |=> (o_thrust == 8'd254))
    else begin
      err_thrust++;
      $display("Mismatch o_thrust at saturation exp %h got %h", 8'd254, o_thrust);
    end

  a_level: assert property (@(negedge clk_50) disable iff (!i_rst_n)
    o_difficulty == lamp_level(lamps_d1))
    else begin
      err_diff++;
      $display("Mismatch o_difficulty exp %h got %h", lamp_level(lamps_d1), o_difficulty);
    end

  a_overlay: assert property (@(negedge clk_50) disable iff (!i_rst_n)
    o_overlay_en == (|sel_hist))
    else begin
      err_diff++;
      $display("Mismatch o_overlay_en exp %h got %h", |sel_hist, o_overlay_en);
    end

  a_rgb: assert property (@(negedge clk_50) disable iff (!i_rst_n) o_rgb == exp_rgb)
    else begin
      err_video++;
      $display("Mismatch o_rgb exp %h got %h", exp_rgb, o_rgb);
    end

  a_de: assert property (@(negedge clk_50) disable iff (!i_rst_n) o_de == exp_de)
    else begin
      err_video++;
      $display("Mismatch o_de exp %h got %h", exp_de, o_de);
    end

  a_hs: assert property (@(negedge clk_50) disable iff (!i_rst_n) o_hs == exp_hs)
    else begin
      err_video++;
      $display("Mismatch o_hs exp %h got %h", exp_hs, o_hs);
    end

  a_vs: assert property (@(negedge clk_50) disable iff (!i_rst_n) o_vs == exp_vs)
    else begin
      err_video++;
      $display("Mismatch o_vs exp %h got %h", exp_vs, o_vs);
    end

  // i2s receiver, bits taken on each sclk rise
  always @(negedge clk_50) begin
    if (!i_rst_n) begin
      sclk_q        = 1'b0;
      lrck_q        = 1'b0;
      chan_valid    = 1'b0;
      bit_idx       = 0;
      frames_seen   = 0;
      exp_word      = '0;
      mclk_q        = 1'b0;
      mclk_seen     = 1'b0;
      mclk_gap      = 0;
      mclk_per_sclk = 0;
      sclk_started  = 1'b0;
    end else begin
      // 24.576 MHz toggle rate from 50 MHz, each mclk level lasts 2 or 3 clocks
      mclk_gap++;
      if (o_mclk != mclk_q) begin
        if (mclk_seen) begin
          assert (mclk_gap == 2 || mclk_gap == 3) else begin
            err_audio++;
            $display("o_mclk level lasted %0d clocks instead of 2 or 3", mclk_gap);
          end
        end
        if (o_mclk) begin
          mclk_per_sclk++;
        end
        mclk_seen = 1'b1;
        mclk_gap  = 0;
        mclk_q    = o_mclk;
      end
      if (o_sclk && !sclk_q) begin
        // sclk is mclk / 4
        if (sclk_started) begin
          assert (mclk_per_sclk == 4) else begin
            err_audio++;
            $display("o_mclk rose %0d times in one o_sclk period instead of 4", mclk_per_sclk);
          end
        end
        sclk_started  = 1'b1;
        mclk_per_sclk = 0;
        if (o_lrck != lrck_q) begin
          if (chan_valid) begin
            assert (bit_idx == SLOT_BITS) else begin
              err_audio++;
              $display("audio channel lasted %0d sclk cycles instead of %0d", bit_idx, SLOT_BITS);
            end
          end
          // lrck low starts the frame with a fresh sample
          if (!o_lrck) begin
            chan_valid = 1'b1;
            frames_seen++;
            exp_word = {1'b0, i_audio[7:1], 1'b0, i_audio[7:1]};
          end
          bit_idx = 0;
          lrck_q  = o_lrck;
        end
        if (chan_valid) begin
          exp_bit = (bit_idx < WORD_BITS) ? exp_word[WORD_BITS-1-bit_idx] : 1'b0;
          assert (o_dac == exp_bit) else begin
            err_audio++;
            $display("Mismatch o_dac bit %0d exp %h got %h", bit_idx, exp_bit, o_dac);
          end
        end
        bit_idx++;
      end
      sclk_q = o_sclk;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_random_keys(input int cycles);
    repeat (cycles) begin
      @(negedge clk_50);
      // sparse presses, each key down about a quarter of the time
      i_pad1_key = pad_key_t'($urandom & $urandom);
      i_pad2_key = pad_key_t'($urandom & $urandom);
    end
  endtask

  task automatic press_select(input int cycles);
    @(negedge clk_50);
    i_pad1_key = '0;
    i_pad2_key = '0;
    // overlay from the random keys runs out first
    repeat (HOLD_CYCLES + 8) @(negedge clk_50);
    i_pad2_key[KEY_SELECT] = 1'b1;
    repeat (cycles) @(negedge clk_50);
    i_pad2_key[KEY_SELECT] = 1'b0;
    repeat (HOLD_CYCLES + 8) @(negedge clk_50);
  endtask

  task automatic sweep_thrust();
    @(negedge clk_50);
    i_pad1_key        = '0;
    i_pad1_key[KEY_A] = 1'b1;
    repeat (SWEEP_TICKS * TICK_CYCLES) @(negedge clk_50);
    assert (o_thrust == 8'd254) else begin
      err_thrust++;
      $display("Mismatch o_thrust after A exp %h got %h", 8'd254, o_thrust);
    end
    i_pad1_key[KEY_A] = 1'b0;
    i_pad1_key[KEY_B] = 1'b1;
    repeat (SWEEP_TICKS * TICK_CYCLES) @(negedge clk_50);
    assert (o_thrust == 8'd0) else begin
      err_thrust++;
      $display("Mismatch o_thrust after B exp %h got %h", 8'd0, o_thrust);
    end
    i_pad1_key = '0;
  endtask

  task automatic drive_lamps(input int cycles);
    repeat (cycles) begin
      @(negedge clk_50);
      i_lamps = lamp_bits_t'($urandom);
    end
  endtask

  task automatic drive_video(input int cycles);
    game_video_t v;
    repeat (cycles) begin
      @(negedge clk_50);
      v        = game_video_t'($urandom);
      v.hblank = ($urandom_range(3) == 0);
      v.vblank = ($urandom_range(7) == 0);
      i_video  = v;
      // pixel strobe on about half the cycles
      i_pix_en = $urandom_range(1);
    end
    @(negedge clk_50);
    i_pix_en = 1'b0;
  endtask

  task automatic play_audio(input int frames);
    repeat (frames) begin
      // change during the right channel, left takes it next
      @(posedge o_lrck);
      @(negedge clk_50);
      i_audio = audio_sample_t'($urandom);
    end
    @(negedge o_lrck);
    @(negedge o_lrck);
  endtask

  task automatic print_counts();
    $display("errors: ctrl %0d thrust %0d difficulty %0d video %0d audio %0d",
             err_ctrl, err_thrust, err_diff, err_video, err_audio);
  endtask

  initial begin
    clk_50 = 1'b0;
    forever #2 clk_50 = ~clk_50;
  end

  always @(posedge clk_50) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, stimulus did not complete within %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    void'($urandom(4291));
    i_rst_n    = 1'b0;
    i_pad1_key = '0;
    i_pad2_key = '0;
    i_lamps    = '0;
    i_pix_en   = 1'b0;
    i_video    = '0;
    i_audio    = '0;
    repeat (3) @(posedge clk_50);
    @(negedge clk_50);
    i_rst_n = 1'b1;
    fork
      begin
        drive_random_keys(200);
        press_select(5);
        sweep_thrust();
      end
      drive_lamps(400);
      drive_video(800);
      play_audio(5);
    join
    repeat (4) @(negedge clk_50);
    assert (frames_seen >= 5) else begin
      err_audio++;
      $display("only %0d audio frames were received", frames_seen);
    end
    print_counts();
    if ((err_ctrl + err_thrust + err_diff + err_video + err_audio) == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
